// File: iseq_pkg.sv
package iseq_pkg;

  localparam int n_lanes  = 4;
  localparam int ra_width = 13;

  // default dram timing in controller cycles
  localparam int unsigned t_ras = 21;
  localparam int unsigned t_rp  = 10;
  localparam int unsigned t_rc  = 32;

  typedef enum logic [3:0] {
    op_nop       = 4'h0,
    op_act       = 4'h1,
    op_pre       = 4'h2,
    op_read      = 4'h3,
    op_wait      = 4'h4,
    op_write     = 4'h5,
    op_rowhammer = 4'h6
  } opcode_e;

  typedef struct packed {
    logic [9:0]          bank;
    logic [ra_width-1:0] row;
  } addr_t;

  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] count;  // repeat count, rowhammer only
    addr_t      addr;
  } instr_t;

  // same 32 bits, seen as a wait word
  typedef struct packed {
    opcode_e     opcode;
    logic [27:0] cycles;
  } wait_t;

  typedef struct packed {
    opcode_e op;
    addr_t   addr;
  } dram_cmd_t;

  function automatic instr_t make_wait(input logic [27:0] cycles);
    wait_t w;
    w.opcode = op_wait;
    w.cycles = cycles;
    return instr_t'(w);
  endfunction

  function automatic logic [27:0] wait_cycles(input instr_t i);
    wait_t w;
    w = wait_t'(i);
    return w.cycles;
  endfunction

  function automatic instr_t make_instr(input opcode_e op, input addr_t addr);
    instr_t i;
    i.opcode = op;
    i.count  = 5'd1;
    i.addr   = addr;
    return i;
  endfunction

endpackage

// File: instr_slot_reg.sv
`timescale 1ns/1ns

module instr_slot_reg
  import iseq_pkg::*;
(
  input  logic   clk,
  input  logic   rstn,

  input  logic   in_valid,
  input  instr_t in_data,
  output logic   in_ready,

  output logic   out_valid,
  output instr_t out_data,
  input  logic   out_ready
);

  logic   full;
  instr_t word;

  // empty, or the held word leaves this cycle
  assign in_ready = !full || out_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      word <= in_data;
    end
  end

  assign out_valid = full;
  assign out_data  = word;

endmodule

// File: lane_arbiter.sv
`timescale 1ns/1ns

module lane_arbiter
  import iseq_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               process_iseq,

  input  instr_t             lane_data [n_lanes],
  input  logic [n_lanes-1:0] lane_empty,
  output logic [n_lanes-1:0] lane_rd,

  input  logic               pipe_idle,
  output logic               busy,

  output logic               out_valid,
  output instr_t             out_data,
  input  logic               out_ready
);

  localparam int ptr_w = $clog2(n_lanes);

  logic             busy_r;
  logic             busy_ns;
  logic [ptr_w-1:0] ptr;
  logic [ptr_w-1:0] ptr_nxt;
  logic             all_empty;
  logic             cur_ok;
  logic             pop;

  assign all_empty = &lane_empty;

  ////////////////////////////////////////////////////////////////////////////
  // busy control
  ////////////////////////////////////////////////////////////////////////////

  // hold until every lane and the whole stream are drained
  always_comb begin
    busy_ns = process_iseq || (busy_r && !(all_empty && pipe_idle));
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_r <= 1'b0;
    end else begin
      busy_r <= busy_ns;
    end
  end

  assign busy = busy_r;

  ////////////////////////////////////////////////////////////////////////////
  // round-robin fetch
  ////////////////////////////////////////////////////////////////////////////

  // only the current lane is offered, so its head stays stable until popped
  assign cur_ok    = busy_r && !lane_empty[ptr];
  assign out_valid = cur_ok;
  assign out_data  = lane_data[ptr];
  assign pop       = cur_ok && out_ready;

  always_comb begin
    lane_rd      = '0;
    lane_rd[ptr] = pop;
  end

  assign ptr_nxt = (ptr == ptr_w'(n_lanes - 1)) ? '0 : ptr + 1'b1;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ptr <= '0;
    end else if (pop) begin
      ptr <= ptr_nxt;
    end else if (busy_r && lane_empty[ptr] && !all_empty) begin
      ptr <= ptr_nxt;  // skip empty lane
    end
  end

endmodule

// File: hammer_expander.sv
`timescale 1ns/1ns

module hammer_expander
  import iseq_pkg::*;
#(
  parameter int unsigned hammer_base = 1000,
  parameter int unsigned t_ras       = iseq_pkg::t_ras,
  parameter int unsigned t_rp        = iseq_pkg::t_rp,
  parameter int unsigned t_rc        = iseq_pkg::t_rc
)
(
  input  logic   clk,
  input  logic   rstn,

  input  logic   in_valid,
  input  instr_t in_data,
  output logic   in_ready,

  output logic   out_valid,
  output instr_t out_data,
  input  logic   out_ready,

  output logic   idle
);

  // largest count field times the base
  localparam int cnt_w = $clog2(31 * hammer_base + 1);

  typedef enum logic [1:0] {
    st_pass,
    st_group,
    st_close
  } state_e;

  state_e           state;
  logic [1:0]       phase;  // act, wait ras, pre, wait rp
  logic [cnt_w-1:0] rep_cnt;
  logic [cnt_w-1:0] load_cnt;
  addr_t            haddr;
  addr_t            pre_addr;
  logic             is_hammer;
  logic             take_hammer;
  logic             out_fire;
  instr_t           gen_word;

  assign is_hammer   = in_data.opcode == op_rowhammer;
  assign take_hammer = (state == st_pass) && in_valid && is_hammer;
  assign out_fire    = out_valid && out_ready;
  assign load_cnt    = cnt_w'(in_data.count * hammer_base);
  assign pre_addr    = '{bank: haddr.bank, row: '0};

  ////////////////////////////////////////////////////////////////////////////
  // generated word
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    gen_word = make_wait(28'(t_rc));  // closing trc wait
    if (state == st_group) begin
      case (phase)
        2'd0:    gen_word = make_instr(op_act, haddr);
        2'd1:    gen_word = make_wait(28'(t_ras));
        2'd2:    gen_word = make_instr(op_pre, pre_addr);
        default: gen_word = make_wait(28'(t_rp));
      endcase
    end
  end

  // plain words go straight through, zero latency
  always_comb begin
    if (state == st_pass) begin
      out_valid = in_valid && !is_hammer;
      out_data  = in_data;
      in_ready  = is_hammer ? 1'b1 : out_ready;
    end else begin
      out_valid = 1'b1;
      out_data  = gen_word;
      in_ready  = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= st_pass;
      phase   <= 2'd0;
      rep_cnt <= '0;
    end else begin
      case (state)
        st_pass: begin
          if (take_hammer) begin
            phase   <= 2'd0;
            rep_cnt <= load_cnt;
            state   <= (load_cnt == '0) ? st_close : st_group;
          end
        end
        st_group: begin
          if (out_fire) begin
            phase <= phase + 2'd1;
            if (phase == 2'd3) begin
              rep_cnt <= rep_cnt - 1'b1;  // one group done
              if (rep_cnt == cnt_w'(1)) begin
                state <= st_close;
              end
            end
          end
        end
        st_close: begin
          if (out_fire) begin
            state <= st_pass;
          end
        end
        default: begin
          state <= st_pass;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_hammer) begin
      haddr <= in_data.addr;
    end
  end

  assign idle = state == st_pass;

endmodule

// File: cmd_issuer.sv
`timescale 1ns/1ns

module cmd_issuer
  import iseq_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,

  input  logic      in_valid,
  input  instr_t    in_data,
  output logic      in_ready,

  input  logic      rdback_fifo_full,

  output logic      cmd_valid,
  output dram_cmd_t cmd,
  output logic      idle
);

  logic [27:0] wait_cnt;
  logic        is_cmd;
  logic        is_wait;
  logic        read_hold;
  logic        accept;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (in_data.opcode)
      op_act, op_pre, op_read, op_write: is_cmd = 1'b1;
      default:                           is_cmd = 1'b0;  // nop and unknown
    endcase
  end

  assign is_wait   = in_data.opcode == op_wait;
  assign read_hold = (in_data.opcode == op_read) && rdback_fifo_full;

  // stalled by a running wait, or a read with no readback room
  assign in_ready = (wait_cnt == '0) && !read_hold;
  assign accept   = in_valid && in_ready;

  ////////////////////////////////////////////////////////////////////////////
  // wait timer and command pulse
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wait_cnt <= '0;
    end else if (accept && is_wait) begin
      wait_cnt <= wait_cycles(in_data);
    end else if (wait_cnt != '0) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= accept && is_cmd;  // single cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (accept && is_cmd) begin
      cmd.op   <= in_data.opcode;
      cmd.addr <= in_data.addr;
    end
  end

  // nothing pending once the pulse is out and the timer expired
  assign idle = (wait_cnt == '0) && !cmd_valid;

endmodule

// File: iseq_dispatcher.sv
`timescale 1ns/1ns

module iseq_dispatcher
  import iseq_pkg::*;
#(
  parameter int unsigned hammer_base = 1000
)
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               process_iseq,
  input  logic               rdback_fifo_full,
  input  instr_t             lane_data [n_lanes],
  input  logic [n_lanes-1:0] lane_empty,
  output logic [n_lanes-1:0] lane_rd,
  output logic               busy,
  output logic               cmd_valid,
  output dram_cmd_t          cmd
);

  logic   arb_valid, arb_ready;
  instr_t arb_data;
  logic   exp_valid, exp_ready, exp_idle;
  instr_t exp_data;
  logic   slot_valid, slot_ready;
  instr_t slot_data;
  logic   iss_idle;
  logic   pipe_idle;

  // no word anywhere between the lanes and the command output
  assign pipe_idle = exp_idle && !slot_valid && iss_idle;

  lane_arbiter lane_arbiter_inst (
    .clk          (clk),
    .rstn         (rstn),
    .process_iseq (process_iseq),
    .lane_data    (lane_data),
    .lane_empty   (lane_empty),
    .lane_rd      (lane_rd),
    .pipe_idle    (pipe_idle),
    .busy         (busy),
    .out_valid    (arb_valid),
    .out_data     (arb_data),
    .out_ready    (arb_ready)
  );

  hammer_expander #(
    .hammer_base (hammer_base),
    .t_ras       (t_ras),
    .t_rp        (t_rp),
    .t_rc        (t_rc)
  ) hammer_expander_inst (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (arb_valid),
    .in_data   (arb_data),
    .in_ready  (arb_ready),
    .out_valid (exp_valid),
    .out_data  (exp_data),
    .out_ready (exp_ready),
    .idle      (exp_idle)
  );

  instr_slot_reg instr_slot_reg_inst (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (exp_valid),
    .in_data   (exp_data),
    .in_ready  (exp_ready),
    .out_valid (slot_valid),
    .out_data  (slot_data),
    .out_ready (slot_ready)
  );

  cmd_issuer cmd_issuer_inst (
    .clk              (clk),
    .rstn             (rstn),
    .in_valid         (slot_valid),
    .in_data          (slot_data),
    .in_ready         (slot_ready),
    .rdback_fifo_full (rdback_fifo_full),
    .cmd_valid        (cmd_valid),
    .cmd              (cmd),
    .idle             (iss_idle)
  );

endmodule

// File: iseq_props.sv
`timescale 1ns/1ns

module iseq_props
  import iseq_pkg::*;
(
  input logic               clk,
  input logic               rstn,
  input logic               process_iseq,
  input logic               rdback_fifo_full,
  input logic [n_lanes-1:0] lane_rd,
  input logic               busy,
  input logic               cmd_valid,
  input dram_cmd_t          cmd,
  input logic               exp_valid,
  input logic               exp_ready,
  input logic               exp_idle,
  input instr_t             exp_data
);

  logic    started;   // process_iseq seen since reset
  opcode_e last_gen;  // last act or pre out of a hammer
  logic    gen_fire;

  assign gen_fire = exp_valid && exp_ready && !exp_idle &&
                    (exp_data.opcode == op_act || exp_data.opcode == op_pre);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      started <= 1'b0;
    end else if (process_iseq) begin
      started <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      last_gen <= op_pre;
    end else if (exp_idle) begin
      last_gen <= op_pre;  // next hammer opens with act
    end else if (gen_fire) begin
      last_gen <= exp_data.opcode;
    end
  end

  quiet_before_start: assert property (@(posedge clk) disable iff (!rstn)
    !started |-> !busy && !cmd_valid && lane_rd == '0)
    else $error("busy, cmd_valid or lane_rd active before process_iseq");

  read_hold_off: assert property (@(posedge clk) disable iff (!rstn)
    cmd_valid && cmd.op == op_read |-> !$past(rdback_fifo_full))
    else $error("read issued right after a cycle with the readback fifo full");

  hammer_alternates: assert property (@(posedge clk) disable iff (!rstn)
    gen_fire |-> exp_data.opcode != last_gen)
    else $error("hammer sequence broke the act/pre alternation");

endmodule

bind iseq_dispatcher iseq_props iseq_props_inst (
  .clk              (clk),
  .rstn             (rstn),
  .process_iseq     (process_iseq),
  .rdback_fifo_full (rdback_fifo_full),
  .lane_rd          (lane_rd),
  .busy             (busy),
  .cmd_valid        (cmd_valid),
  .cmd              (cmd),
  .exp_valid        (exp_valid),
  .exp_ready        (exp_ready),
  .exp_idle         (exp_idle),
  .exp_data         (exp_data)
);

// File: tb_iseq_dispatcher.sv
`timescale 1ns/1ns

module tb_iseq_dispatcher
  import iseq_pkg::*;
();

  localparam int unsigned hammer_base = 2;

  logic               clk = 1'b0;
  logic               rstn;
  logic               process_iseq;
  logic               rdback_fifo_full;
  instr_t             lane_data [n_lanes];
  logic [n_lanes-1:0] lane_empty;
  logic [n_lanes-1:0] lane_rd;
  logic               busy;
  logic               cmd_valid;
  dram_cmd_t          cmd;

  instr_t             lane_q [n_lanes][$];  // head first
  dram_cmd_t          exp_q [$];
  int unsigned        gap_q [$];  // wait cycles owed before each command
  integer             seed = 32'h72d0dd94;
  int unsigned        cycle = 0;
  int unsigned        deadline = 2000;
  int unsigned        last_pulse = 0;
  int unsigned        pend_wait;
  int unsigned        run_cost;
  logic               pulsed = 1'b0;
  logic               running = 1'b0;
  logic [n_lanes-1:0] rd_seen;

  iseq_dispatcher #(
    .hammer_base (hammer_base)
  ) iseq_dispatcher_inst (
    .clk              (clk),
    .rstn             (rstn),
    .process_iseq     (process_iseq),
    .rdback_fifo_full (rdback_fifo_full),
    .lane_data        (lane_data),
    .lane_empty       (lane_empty),
    .lane_rd          (lane_rd),
    .busy             (busy),
    .cmd_valid        (cmd_valid),
    .cmd              (cmd)
  );

  always #4 clk = ~clk;

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  function automatic addr_t rand_addr();
    addr_t a;
    a.bank = 10'($random(seed));
    a.row  = 13'($random(seed));
    return a;
  endfunction

  function automatic instr_t pack_instr(input opcode_e op, input logic [4:0] count,
                                        input addr_t a);
    instr_t w;
    w.opcode = op;
    w.count  = count;
    w.addr   = a;
    return w;
  endfunction

  function automatic instr_t wait_word(input logic [27:0] n);
    wait_t wv;
    wv.opcode = op_wait;
    wv.cycles = n;
    return instr_t'(wv);
  endfunction

  function automatic void update_lane_heads();
    for (int l = 0; l < n_lanes; l++) begin
      lane_empty[l] = lane_q[l].size() == 0;
      lane_data[l]  = lane_empty[l] ? '0 : lane_q[l][0];
    end
  endfunction

  function automatic logic lanes_drained();
    for (int l = 0; l < n_lanes; l++) begin
      if (lane_q[l].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // expected command stream
  ////////////////////////////////////////////////////////////////////////////

  function automatic void note_wait(input int unsigned n);
    pend_wait += n;
    run_cost  += n + 1;
  endfunction

  function automatic void expect_cmd(input opcode_e op, input addr_t a);
    dram_cmd_t c;
    c.op   = op;
    c.addr = a;
    exp_q.push_back(c);
    gap_q.push_back(pend_wait);
    pend_wait = 0;
    run_cost += 1;
  endfunction

  // round-robin merge of the loaded lanes, hammers expanded in place
  function automatic void expect_stream();
    int unsigned depth;
    instr_t      w;
    wait_t       wv;
    addr_t       pre_a;
    depth = 0;
    for (int l = 0; l < n_lanes; l++) begin
      if (lane_q[l].size() > depth) depth = lane_q[l].size();
    end
    for (int unsigned k = 0; k < depth; k++) begin
      for (int l = 0; l < n_lanes; l++) begin
        if (k < lane_q[l].size()) begin
          w = lane_q[l][k];
          case (w.opcode)
            op_nop: ;
            op_wait: begin
              wv = wait_t'(w);
              note_wait(32'(wv.cycles));
            end
            op_rowhammer: begin
              pre_a      = w.addr;
              pre_a.row  = '0;
              for (int unsigned g = 0; g < w.count * hammer_base; g++) begin
                expect_cmd(op_act, w.addr);
                note_wait(t_ras);
                expect_cmd(op_pre, pre_a);
                note_wait(t_rp);
              end
              note_wait(t_rc);
            end
            default: expect_cmd(w.opcode, w.addr);
          endcase
        end
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // lane fifo models and output checks
  ////////////////////////////////////////////////////////////////////////////

  always begin
    @(negedge clk);
    rd_seen = lane_rd;
    @(posedge clk);
    #1;
    for (int l = 0; l < n_lanes; l++) begin
      if (rd_seen[l]) begin
        assert (lane_q[l].size() != 0)
          else report_failure("lane_rd pulsed on a lane that was empty");
        void'(lane_q[l].pop_front());
      end
    end
    update_lane_heads();
    rdback_fifo_full = ($random(seed) & 3) == 0;  // full about a quarter of the time
  end

  task automatic check_cmd();
    dram_cmd_t want;
    int unsigned gap;
    assert (exp_q.size() != 0)
      else report_failure("command pulse seen with no command left to expect");
    want = exp_q.pop_front();
    gap  = gap_q.pop_front();
    assert (cmd == want)
      else report_failure($sformatf("FAIL at %0t ns: cmd expected %h, got %h",
                                    $time, want, cmd));
    if (pulsed) begin
      assert (cycle - last_pulse > gap)
        else report_failure($sformatf("FAIL at %0t ns: cmd_valid spacing expected > %0d, got %0d",
                                      $time, gap, cycle - last_pulse));
    end
    pulsed     = 1'b1;
    last_pulse = cycle;
  endtask

  always @(negedge clk) begin
    cycle = cycle + 1;
    if (busy) running = 1'b1;
    if (cmd_valid) check_cmd();
    assert (!running || busy || lanes_drained())
      else report_failure("busy went low while a lane still held instructions");
  end

  // watchdog, deadline moves with each run
  always @(posedge clk) begin
    if (cycle > deadline) begin
      $display("timeout: the run did not finish by cycle %0d", deadline);
      $display("** FAIL **");
      $fatal(1, "watchdog expired");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // programs
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_plain_program();
    addr_t a;
    a = rand_addr();
    lane_q[0].push_back(pack_instr(op_act, 5'd1, a));
    lane_q[0].push_back(pack_instr(op_read, 5'd1, a));
    lane_q[0].push_back(wait_word(28'd40));
    lane_q[0].push_back(pack_instr(op_pre, 5'd1, a));
    lane_q[1].push_back(pack_instr(op_write, 5'd1, rand_addr()));
    lane_q[1].push_back(pack_instr(op_nop, 5'd0, '0));
    lane_q[1].push_back(pack_instr(op_read, 5'd1, rand_addr()));
    lane_q[2].push_back(wait_word(28'd5));
    for (int i = 0; i < 6; i++) begin
      lane_q[3].push_back(pack_instr(i[0] ? op_read : op_write, 5'd1, rand_addr()));
    end
  endtask

  task automatic load_hammer_program();
    lane_q[0].push_back(pack_instr(op_rowhammer, 5'd1, rand_addr()));
    lane_q[0].push_back(pack_instr(op_read, 5'd1, rand_addr()));
    lane_q[1].push_back(pack_instr(op_rowhammer, 5'd0, rand_addr()));  // closing wait only
    lane_q[2].push_back(pack_instr(op_act, 5'd1, rand_addr()));
    lane_q[2].push_back(pack_instr(op_rowhammer, 5'd2, rand_addr()));
    lane_q[2].push_back(pack_instr(op_write, 5'd1, rand_addr()));
  endtask

  task automatic run_phase();
    pend_wait = 0;
    run_cost  = 0;
    running   = 1'b0;
    expect_stream();
    deadline = cycle + 4 * run_cost + 2000;
    update_lane_heads();
    process_iseq = 1'b1;
    @(posedge clk);
    #1;
    process_iseq = 1'b0;
    wait (busy);
    wait (!busy);
    @(posedge clk);
    #1;
    assert (exp_q.size() == 0)
      else report_failure($sformatf("busy fell with %0d commands never issued", exp_q.size()));
  endtask

  initial begin
    rstn             = 1'b0;
    process_iseq     = 1'b0;
    rdback_fifo_full = 1'b0;
    update_lane_heads();
    repeat (10) @(posedge clk);
    #1;
    rstn = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    load_plain_program();
    run_phase();
    load_hammer_program();
    run_phase();
    $display("** PASS **");
    $finish;
  end

endmodule

// File: filelist.f
iseq_pkg.sv
instr_slot_reg.sv
lane_arbiter.sv
hammer_expander.sv
cmd_issuer.sv
iseq_dispatcher.sv
iseq_props.sv
tb_iseq_dispatcher.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_iseq_dispatcher
FILELIST  := filelist.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '^\*\* FAIL \*\*$$' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '^\*\* PASS \*\*$$' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
